//--- src/core_defs.svh
// Register map and widths for a single dsp_clk domain with an 8-bit settings address space
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

////////////////////////////////////////
// Settings bus
`define SET_ADDR_W 8
`define SET_DATA_W 32

// Register bases
`define SR_MISC    0     // 7 regs
`define SR_TIME64  10    // 3 regs
`define SR_DIVSW   180   // 2 regs

////////////////////////////////////////
// Widths and reset values
`define TIME_W        64
`define RB_WORDS      16
`define LED_W         8
`define LED_SRC_RESET 8'h1E   // LEDs 1 to 4 follow hardware

// Compatibility number
// Bump the minor number for any change software can see
`define COMPAT_MAJOR 8
`define COMPAT_MINOR 2

`endif

//--- src/ctrl_pkg.sv
// Settings bus and boot controller types with widths taken from core_defs.svh
`include "core_defs.svh"

package ctrl_pkg;

   ////////////////////////////////////////
   // Settings bus

   typedef logic [`SET_ADDR_W-1:0] set_addr_t;
   typedef logic [`SET_DATA_W-1:0] set_data_t;

   ////////////////////////////////////////
   // Boot handoff

   typedef enum logic {
      BOOT_WAIT = 1'b0,   // Bootloader running
      BOOT_DONE = 1'b1    // Left only by power on reset
   } boot_state_e;

endpackage

//--- src/time_pkg.sv
// VITA time types; the readback index must cover RB_WORDS words
`include "core_defs.svh"

package time_pkg;

   typedef logic [`TIME_W-1:0] vita_time_t;

   // Load command in bit 0 of the load register
   typedef enum logic {
      LOAD_NOW    = 1'b0,
      LOAD_ON_PPS = 1'b1
   } time_load_e;

   // Only these readback words carry data
   typedef enum logic [$clog2(`RB_WORDS)-1:0] {
      RB_TIME_HI = 4'd10,
      RB_TIME_LO = 4'd11,
      RB_COMPAT  = 4'd12,
      RB_STATUS  = 4'd13,
      RB_PPS_HI  = 4'd14,
      RB_PPS_LO  = 4'd15
   } rb_word_e;

endpackage

//--- src/boot_reset_ctrl.sv
// Core reset follows por_rst with one cycle of lag and pulses once on the first bootloader done
module boot_reset_ctrl
   import ctrl_pkg::*;
(
   input  logic dsp_clk,
   input  logic por_rst,
   input  logic bldr_done_i,
   output logic core_rst_o
);

   boot_state_e state;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state      <= BOOT_WAIT;
         core_rst_o <= 1'b1;   // Held one cycle past por
      end else begin
         case (state)
            BOOT_WAIT: begin
               core_rst_o <= bldr_done_i;   // Single pulse on handoff
               if (bldr_done_i) begin
                  state <= BOOT_DONE;
               end
            end

            // Later done writes have no effect
            BOOT_DONE: begin
               core_rst_o <= 1'b0;
            end

            default: begin
               state      <= BOOT_WAIT;
               core_rst_o <= 1'b0;
            end
         endcase
      end
   end

endmodule

//--- src/misc_ctrl_regs.sv
// Misc control registers update one cycle after the strobe; core_rst_i restores all reset values
`include "core_defs.svh"

module misc_ctrl_regs
   import ctrl_pkg::*;
(
   input  logic              dsp_clk,
   input  logic              core_rst_i,
   input  logic              set_stb_i,
   input  set_addr_t         set_addr_i,
   input  set_data_t         set_data_i,
   input  logic              run_rx_i,
   input  logic              run_tx_i,
   input  logic              clk_status_i,
   input  logic              serdes_link_up_i,
   input  logic              good_sync_i,
   output logic              bldr_done_o,
   output logic [`LED_W-1:0] leds_o,
   output logic              clock_ready_o,
   output logic [1:0]        clk_en_o,
   output logic [1:0]        clk_sel_o,
   output logic [3:0]        ser_ctrl_o,
   output logic [3:0]        adc_ctrl_o,
   output logic              phy_reset_n_o,
   output logic [1:0]        div_sw_o
);

   localparam set_addr_t ADDR_CLK     = set_addr_t'(`SR_MISC + 0);
   localparam set_addr_t ADDR_SER     = set_addr_t'(`SR_MISC + 1);
   localparam set_addr_t ADDR_ADC     = set_addr_t'(`SR_MISC + 2);
   localparam set_addr_t ADDR_LED_SW  = set_addr_t'(`SR_MISC + 3);
   localparam set_addr_t ADDR_PHY     = set_addr_t'(`SR_MISC + 4);
   localparam set_addr_t ADDR_BLDR    = set_addr_t'(`SR_MISC + 5);
   localparam set_addr_t ADDR_LED_SRC = set_addr_t'(`SR_MISC + 6);
   localparam set_addr_t ADDR_DIVSW0  = set_addr_t'(`SR_DIVSW + 0);
   localparam set_addr_t ADDR_DIVSW1  = set_addr_t'(`SR_DIVSW + 1);

   logic [4:0]        clk_ctrl;   // {ready, en[1:0], sel[1:0]}
   logic              phy_reset;
   logic [`LED_W-1:0] led_sw;
   logic [`LED_W-1:0] led_src;    // 1 = hardware, 0 = software
   logic [`LED_W-1:0] led_hw;

   ////////////////////////////////////////
   // Register bank

   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         clk_ctrl    <= '0;
         ser_ctrl_o  <= '0;
         adc_ctrl_o  <= '0;
         led_sw      <= '0;
         phy_reset   <= 1'b0;
         bldr_done_o <= 1'b0;
         led_src     <= `LED_SRC_RESET;
         div_sw_o    <= 2'b11;   // Both switches on
      end else if (set_stb_i) begin
         case (set_addr_i)
            ADDR_CLK:     clk_ctrl    <= set_data_i[4:0];
            ADDR_SER:     ser_ctrl_o  <= set_data_i[3:0];
            ADDR_ADC:     adc_ctrl_o  <= set_data_i[3:0];
            ADDR_LED_SW:  led_sw      <= set_data_i[`LED_W-1:0];
            ADDR_PHY:     phy_reset   <= set_data_i[0];
            ADDR_BLDR:    bldr_done_o <= set_data_i[0];
            ADDR_LED_SRC: led_src     <= set_data_i[`LED_W-1:0];
            ADDR_DIVSW0:  div_sw_o[0] <= set_data_i[0];
            ADDR_DIVSW1:  div_sw_o[1] <= set_data_i[0];
            default: ;
         endcase
      end
   end

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clk_ctrl;
   assign phy_reset_n_o = ~phy_reset;   // Pin is active low

   ////////////////////////////////////////
   // LED mix

   // Link LED only lights once time is synced
   assign led_hw = `LED_W'({run_tx_i, run_rx_i, clk_status_i,
                            serdes_link_up_i & good_sync_i, 1'b0});

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

//--- src/vita_timer.sv
// Free running 64-bit time; pps_i is asynchronous and acts about three cycles after its edge
`include "core_defs.svh"

module vita_timer
   import ctrl_pkg::*;
   import time_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       core_rst_i,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       pps_int_o,
   output logic       good_sync_o
);

   localparam int HALF_W = `TIME_W / 2;

   localparam set_addr_t ADDR_HI   = set_addr_t'(`SR_TIME64 + 0);
   localparam set_addr_t ADDR_LO   = set_addr_t'(`SR_TIME64 + 1);
   localparam set_addr_t ADDR_LOAD = set_addr_t'(`SR_TIME64 + 2);

   logic [HALF_W-1:0] time_hi;
   logic [HALF_W-1:0] time_lo;
   vita_time_t        staged;
   time_load_e        armed;
   logic              load_cmd;
   logic              load_now;
   logic              armed_load;
   logic              pps_s1;
   logic              pps_s2;
   logic              pps_d;
   logic              pps_edge;

   assign staged     = {time_hi, time_lo};
   assign load_cmd   = set_stb_i && (set_addr_i == ADDR_LOAD);
   assign load_now   = load_cmd && (set_data_i[0] == LOAD_NOW);
   assign pps_edge   = pps_s2 & ~pps_d;                  // Rising edge only
   assign armed_load = pps_edge && (armed == LOAD_ON_PPS);

   // Staged time words
   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         time_hi <= '0;
         time_lo <= '0;
      end else begin
         if (set_stb_i && (set_addr_i == ADDR_HI)) begin
            time_hi <= set_data_i[HALF_W-1:0];
         end
         if (set_stb_i && (set_addr_i == ADDR_LO)) begin
            time_lo <= set_data_i[HALF_W-1:0];
         end
      end
   end

   ////////////////////////////////////////
   // PPS synchronizer and edge detect

   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         pps_s1    <= 1'b0;
         pps_s2    <= 1'b0;
         pps_d     <= 1'b0;
         pps_int_o <= 1'b0;
      end else begin
         pps_s1    <= pps_i;
         pps_s2    <= pps_s1;
         pps_d     <= pps_s2;
         pps_int_o <= pps_edge;
      end
   end

   ////////////////////////////////////////
   // Counter, arm and latch

   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         armed           <= LOAD_NOW;
         good_sync_o     <= 1'b0;
      end else begin
         if (load_now || armed_load) begin
            vita_time_o <= staged;
         end else begin
            vita_time_o <= vita_time_o + 1'b1;
         end

         if (pps_edge) begin
            vita_time_pps_o <= armed_load ? staged : vita_time_o;
         end

         // A new command overrides a pending arm
         if (load_cmd) begin
            armed <= time_load_e'(set_data_i[0]);
         end else if (armed_load) begin
            armed       <= LOAD_NOW;
            good_sync_o <= 1'b1;
         end
      end
   end

endmodule

//--- src/readback_mux.sv
// Readback word appears one cycle after rb_addr_i is sampled; unnamed words read zero
`include "core_defs.svh"

module readback_mux
   import time_pkg::*;
(
   input  logic                   dsp_clk,
   input  logic                   core_rst_i,
   input  rb_word_e               rb_addr_i,
   input  vita_time_t             vita_time_i,
   input  vita_time_t             vita_time_pps_i,
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,
   input  logic                   button_i,
   output logic [`SET_DATA_W-1:0] rb_data_o
);

   localparam int HALF_W = `TIME_W / 2;

   // {major, minor}
   localparam logic [`SET_DATA_W-1:0] COMPAT_NUM = {16'(`COMPAT_MAJOR), 16'(`COMPAT_MINOR)};

   logic [`SET_DATA_W-1:0] status_word;

   // Button at 13, clock status at 11, link at 10
   assign status_word = {18'b0, button_i, 1'b0, clk_status_i, serdes_link_up_i, 10'b0};

   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         rb_data_o <= '0;
      end else begin
         case (rb_addr_i)
            RB_TIME_HI: rb_data_o <= vita_time_i[`TIME_W-1:HALF_W];
            RB_TIME_LO: rb_data_o <= vita_time_i[HALF_W-1:0];
            RB_COMPAT:  rb_data_o <= COMPAT_NUM;
            RB_STATUS:  rb_data_o <= status_word;
            RB_PPS_HI:  rb_data_o <= vita_time_pps_i[`TIME_W-1:HALF_W];
            RB_PPS_LO:  rb_data_o <= vita_time_pps_i[HALF_W-1:0];
            default:    rb_data_o <= '0;
         endcase
      end
   end

endmodule

//--- src/core_top.sv
// Control and status core on one dsp_clk; settings writes have no back-pressure
`include "core_defs.svh"

module core_top
   import ctrl_pkg::*;
   import time_pkg::*;
(
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  logic                   set_stb_i,
   input  set_addr_t              set_addr_i,
   input  set_data_t              set_data_i,
   input  rb_word_e               rb_addr_i,
   output logic [`SET_DATA_W-1:0] rb_data_o,
   input  logic                   pps_i,
   input  logic                   run_rx_i,
   input  logic                   run_tx_i,
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,
   input  logic                   button_i,
   output logic [`LED_W-1:0]      leds_o,
   output logic                   clock_ready_o,
   output logic [1:0]             clk_en_o,
   output logic [1:0]             clk_sel_o,
   output logic [3:0]             ser_ctrl_o,
   output logic [3:0]             adc_ctrl_o,
   output logic                   phy_reset_n_o,
   output logic [1:0]             div_sw_o,
   output logic                   pps_int_o,
   output logic                   core_rst_o
);

   logic       bldr_done;
   logic       good_sync;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   ////////////////////////////////////////
   // Reset

   boot_reset_ctrl u_boot (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .bldr_done_i (bldr_done),
      .core_rst_o  (core_rst_o)   // Also resets the blocks below
   );

   ////////////////////////////////////////
   // Settings and status

   misc_ctrl_regs u_regs (
      .dsp_clk          (dsp_clk),
      .core_rst_i       (core_rst_o),
      .set_stb_i        (set_stb_i),
      .set_addr_i       (set_addr_i),
      .set_data_i       (set_data_i),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .good_sync_i      (good_sync),
      .bldr_done_o      (bldr_done),
      .leds_o           (leds_o),
      .clock_ready_o    (clock_ready_o),
      .clk_en_o         (clk_en_o),
      .clk_sel_o        (clk_sel_o),
      .ser_ctrl_o       (ser_ctrl_o),
      .adc_ctrl_o       (adc_ctrl_o),
      .phy_reset_n_o    (phy_reset_n_o),
      .div_sw_o         (div_sw_o)
   );

   vita_timer u_timer (
      .dsp_clk         (dsp_clk),
      .core_rst_i      (core_rst_o),
      .set_stb_i       (set_stb_i),
      .set_addr_i      (set_addr_i),
      .set_data_i      (set_data_i),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .pps_int_o       (pps_int_o),
      .good_sync_o     (good_sync)
   );

   readback_mux u_rb (
      .dsp_clk          (dsp_clk),
      .core_rst_i       (core_rst_o),
      .rb_addr_i        (rb_addr_i),
      .vita_time_i      (vita_time),
      .vita_time_pps_i  (vita_time_pps),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .button_i         (button_i),
      .rb_data_o        (rb_data_o)
   );

endmodule

//--- bench/core_checker.sv
// Samples the DUT outputs when a check is called; a check on an unknown output name is a failure
`include "core_defs.svh"

module core_checker (
   input  logic [`LED_W-1:0]      leds_i,
   input  logic [1:0]             div_sw_i,
   input  logic                   phy_reset_n_i,
   input  logic                   clock_ready_i,
   input  logic [1:0]             clk_en_i,
   input  logic [1:0]             clk_sel_i,
   input  logic [3:0]             ser_ctrl_i,
   input  logic [3:0]             adc_ctrl_i,
   input  logic [`SET_DATA_W-1:0] rb_data_i
);

   int pass_count = 0;
   int fail_count = 0;

   ////////////////////////////////////////
   // Output selection by name

   task automatic sample_port(input string sel, output logic [31:0] val, output bit known);
      known = 1'b1;
      val   = '0;
      if (sel == "leds") val = leds_i;
      else if (sel == "div_sw") val = div_sw_i;
      else if (sel == "phy_rst_n") val = phy_reset_n_i;
      else if (sel == "clk_ready") val = clock_ready_i;
      else if (sel == "clk_en") val = clk_en_i;
      else if (sel == "clk_sel") val = clk_sel_i;
      else if (sel == "ser_ctrl") val = ser_ctrl_i;
      else if (sel == "adc_ctrl") val = adc_ctrl_i;
      else if (sel == "rb_data") val = rb_data_i;
      else known = 1'b0;
   endtask

   task automatic check_value(input string name, input string sel, input logic [31:0] exp);
      logic [31:0] act;
      bit          known;
      sample_port(sel, act, known);
      if (!known) begin
         fail_count++;
         $display("FAIL %s: the DUT has no output called %s", name, sel);
      end else if (act !== exp) begin
         fail_count++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end else begin
         pass_count++;
         $display("PASS %s", name);
      end
   endtask

   // Tests that wait on an event rather than compare a value
   task automatic check_event(input string name, input bit ok, input string what);
      if (ok) begin
         pass_count++;
         $display("PASS %s", name);
      end else begin
         fail_count++;
         $display("FAIL %s: %s", name, what);
      end
   endtask

   task automatic report_counts();
      $display("Checks finished: %0d passed, %0d failed", pass_count, fail_count);
   endtask

endmodule

//--- bench/core_tb.sv
// Reads bench/core_stim.txt from the project root; each wait gives up after WAIT_LIMIT cycles
`include "core_defs.svh"

module core_tb
   import ctrl_pkg::*;
   import time_pkg::*;
();

   localparam int WAIT_LIMIT = 20;

   logic                   dsp_clk;
   logic                   por_rst;
   logic                   set_stb;
   set_addr_t              set_addr;
   set_data_t              set_data;
   rb_word_e               rb_addr;
   logic [`SET_DATA_W-1:0] rb_data;
   logic                   pps;
   logic                   run_rx;
   logic                   run_tx;
   logic                   clk_status;
   logic                   link_up;
   logic                   button;
   logic [`LED_W-1:0]      leds;
   logic                   clock_ready;
   logic [1:0]             clk_en;
   logic [1:0]             clk_sel;
   logic [3:0]             ser_ctrl;
   logic [3:0]             adc_ctrl;
   logic                   phy_reset_n;
   logic [1:0]             div_sw;
   logic                   pps_int;
   logic                   core_rst;

   core_top dut (
      .dsp_clk (dsp_clk), .por_rst (por_rst), .set_stb_i (set_stb), .set_addr_i (set_addr),
      .set_data_i (set_data), .rb_addr_i (rb_addr), .rb_data_o (rb_data), .pps_i (pps),
      .run_rx_i (run_rx), .run_tx_i (run_tx), .clk_status_i (clk_status),
      .serdes_link_up_i (link_up), .button_i (button), .leds_o (leds),
      .clock_ready_o (clock_ready), .clk_en_o (clk_en), .clk_sel_o (clk_sel),
      .ser_ctrl_o (ser_ctrl), .adc_ctrl_o (adc_ctrl), .phy_reset_n_o (phy_reset_n),
      .div_sw_o (div_sw), .pps_int_o (pps_int), .core_rst_o (core_rst)
   );

   core_checker u_checker (
      .leds_i (leds), .div_sw_i (div_sw), .phy_reset_n_i (phy_reset_n),
      .clock_ready_i (clock_ready), .clk_en_i (clk_en), .clk_sel_i (clk_sel),
      .ser_ctrl_i (ser_ctrl), .adc_ctrl_i (adc_ctrl), .rb_data_i (rb_data)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #4 dsp_clk = ~dsp_clk;
   end

   ////////////////////////////////////////
   // Bus and pin operations on the falling edge

   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      @(negedge dsp_clk);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      @(negedge dsp_clk);
      set_stb  = 1'b0;   // One-cycle strobe
   endtask

   task automatic read_word(input string name, input logic [3:0] word, input logic [31:0] exp);
      @(negedge dsp_clk);
      rb_addr = rb_word_e'(word);
      @(negedge dsp_clk);   // Registered readback
      u_checker.check_value(name, "rb_data", exp);
   endtask

   task automatic pulse_pps(input string name);
      int cycles;
      bit seen;
      cycles = 0;
      seen   = 1'b0;
      @(negedge dsp_clk);
      pps = 1'b1;
      while (!seen && cycles < WAIT_LIMIT) begin
         @(negedge dsp_clk);
         seen = pps_int;
         cycles++;
      end
      pps = 1'b0;
      u_checker.check_event(name, seen, "pps_int_o did not pulse before the timeout");
   endtask

   task automatic wait_reset_pulse(input string name);
      int cycles;
      bit seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < WAIT_LIMIT) begin
         @(negedge dsp_clk);
         seen = core_rst;
         cycles++;
      end
      u_checker.check_event(name, seen, "core_rst_o did not pulse before the timeout");
   endtask

   task automatic expect_no_reset(input string name);
      int cycles;
      bit seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < WAIT_LIMIT) begin
         @(negedge dsp_clk);
         seen = core_rst;
         cycles++;
      end
      u_checker.check_event(name, !seen, "core_rst_o pulsed a second time");
   endtask

   ////////////////////////////////////////
   // Stimulus file

   task automatic do_op(input string line, input string op);
      string       name;
      string       sel;
      logic [31:0] a;
      logic [31:0] d;
      logic        rx;
      logic        tx;
      logic        cs;
      logic        lk;
      logic        bt;
      int          n;
      int          want;
      n    = 0;
      want = 0;
      if (op == "W") begin
         n    = $sscanf(line, "%s %h %h", op, a, d);
         want = 3;
         write_setting(a[7:0], d);
      end else if (op == "S") begin
         n    = $sscanf(line, "%s %b %b %b %b %b", op, rx, tx, cs, lk, bt);
         want = 6;
         @(negedge dsp_clk);
         run_rx     = rx;
         run_tx     = tx;
         clk_status = cs;
         link_up    = lk;
         button     = bt;
      end else if (op == "R") begin
         n    = $sscanf(line, "%s %s %h %h", op, name, a, d);
         want = 4;
         read_word(name, a[3:0], d);
      end else if (op == "O") begin
         n    = $sscanf(line, "%s %s %s %h", op, name, sel, d);
         want = 4;
         @(negedge dsp_clk);
         u_checker.check_value(name, sel, d);
      end else if (op == "P" || op == "X" || op == "N") begin
         n    = $sscanf(line, "%s %s", op, name);
         want = 2;
         if (op == "P") pulse_pps(name);
         else if (op == "X") wait_reset_pulse(name);
         else expect_no_reset(name);
      end else begin
         u_checker.check_event(op, 1'b0, "the stimulus file has an unknown operation");
      end
      if (n != want) begin
         u_checker.check_event(op, 1'b0, "a stimulus line has too few fields");
      end
   endtask

   task automatic run_stim(input int fd);
      string line;
      string op;
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) != 0 && $sscanf(line, "%s", op) == 1) begin
            if (op.getc(0) != "#") begin
               do_op(line, op);
            end
         end
      end
   endtask

   initial begin
      int fd;
      int cycles;
      por_rst    = 1'b1;
      set_stb    = 1'b0;
      set_addr   = '0;
      set_data   = '0;
      rb_addr    = RB_COMPAT;
      pps        = 1'b0;
      run_rx     = 1'b0;
      run_tx     = 1'b0;
      clk_status = 1'b0;
      link_up    = 1'b0;
      button     = 1'b0;
      repeat (3) @(negedge dsp_clk);
      por_rst = 1'b0;
      cycles  = 0;
      while (core_rst && cycles < WAIT_LIMIT) begin   // Core reset lags por by a cycle
         @(negedge dsp_clk);
         cycles++;
      end
      u_checker.check_event("reset_release", !core_rst, "core_rst_o stayed high after por_rst");
      fd = $fopen("bench/core_stim.txt", "r");
      if (fd == 0) begin
         u_checker.check_event("open_stim", 1'b0, "bench/core_stim.txt could not be opened");
      end else begin
         run_stim(fd);
         $fclose(fd);
      end
      u_checker.report_counts();
      if (u_checker.fail_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- list.f
+incdir+src
src/ctrl_pkg.sv
src/time_pkg.sv
src/boot_reset_ctrl.sv
src/misc_ctrl_regs.sv
src/vita_timer.sv
src/readback_mux.sv
src/core_top.sv
bench/core_checker.sv
bench/core_tb.sv

//--- bench/core_stim.txt
# op fields, values hex: W addr data | S rx tx clk link button | R name word expect
# O name output expect | P name (pps pulse) | X name (reset pulse) | N name (no reset pulse)
S 1 0 1 1 1
O reset_leds leds 0c
O reset_div_sw div_sw 3
O reset_phy phy_rst_n 1
O reset_clk_ready clk_ready 0
R reset_compat c 00080002
W 00 1b
W 01 a5
W 02 3c
W 04 1
W b4 0
O ctrl_clk_ready clk_ready 1
O ctrl_clk_en clk_en 2
O ctrl_clk_sel clk_sel 3
O ctrl_ser ser_ctrl 5
O ctrl_adc adc_ctrl c
O ctrl_phy phy_rst_n 0
O ctrl_div_sw div_sw 2
W 06 f0
W 03 a5
S 1 1 0 1 0
O led_mix leds 15
S 0 0 1 1 1
R status_bits d 00002c00
W 0a 12345678
W 0b 10
W 0c 0
R load_now_hi a 12345678
W 0a cafe0001
W 0b 00abcdef
W 0c 1
P pps_arm
R pps_hi e cafe0001
R pps_lo f 00abcdef
W 06 02
O sync_led leds a7
W 05 1
X boot_pulse
O boot_leds leds 04
O boot_div_sw div_sw 3
O boot_phy phy_rst_n 1
O boot_clk_en clk_en 0
O boot_ser ser_ctrl 0
W 05 1
N boot_once
